// File: zxula_macros.svh
`ifndef ZXULA_MACROS_SVH
`define ZXULA_MACROS_SVH

// active screen in pixels and lines
`define ZX_H_AREA        (256)
`define ZX_V_AREA        (192)

// pixel pipeline delay from fetch to output
`define ZX_SCREEN_DELAY  (8)

// pentagon raster segments
`define ZX_PENT_H_LBORDER (64)
`define ZX_PENT_H_RBORDER (64)
`define ZX_PENT_H_BLANK1  (8)
`define ZX_PENT_H_SYNC    (33)
`define ZX_PENT_H_BLANK2  (23)
`define ZX_PENT_V_BBORDER (56)
`define ZX_PENT_V_SYNC    (8)
`define ZX_PENT_V_TBORDER (64)

// spectrum 128 raster segments
`define ZX_S128_H_LBORDER (40)
`define ZX_S128_H_RBORDER (56)
`define ZX_S128_H_BLANK1  (28)
`define ZX_S128_H_SYNC    (33)
`define ZX_S128_H_BLANK2  (43)
`define ZX_S128_V_BBORDER (56)
`define ZX_S128_V_SYNC    (8)
`define ZX_S128_V_TBORDER (55)

`define ZX_PENT_H_TOTAL (`ZX_H_AREA + `ZX_PENT_H_RBORDER + `ZX_PENT_H_BLANK1 + \
	`ZX_PENT_H_SYNC + `ZX_PENT_H_BLANK2 + `ZX_PENT_H_LBORDER)
`define ZX_PENT_V_TOTAL (`ZX_V_AREA + `ZX_PENT_V_BBORDER + `ZX_PENT_V_SYNC + \
	`ZX_PENT_V_TBORDER)
`define ZX_S128_H_TOTAL (`ZX_H_AREA + `ZX_S128_H_RBORDER + `ZX_S128_H_BLANK1 + \
	`ZX_S128_H_SYNC + `ZX_S128_H_BLANK2 + `ZX_S128_H_LBORDER)
`define ZX_S128_V_TOTAL (`ZX_V_AREA + `ZX_S128_V_BBORDER + `ZX_S128_V_SYNC + \
	`ZX_S128_V_TBORDER)

// frame interrupt windows, line and pixel range
`define ZX_PENT_INT_V      (239)
`define ZX_PENT_INT_H_FROM (318)
`define ZX_PENT_INT_H_TO   (384)
`define ZX_S128_INT_V      (248)
`define ZX_S128_INT_H_FROM (0)
`define ZX_S128_INT_H_TO   (64)

`endif

// File: zxula_pkg.sv
`default_nettype none

package zxula_pkg;

	// pixel column and line number
	typedef logic [8:0] hcount_t;
	typedef logic [8:0] vcount_t;

	// raster format selected by the board strap
	typedef enum logic {
		FMT_PENT = 1'b0,
		FMT_S128 = 1'b1
	} frame_fmt_e;

	typedef struct packed {
		logic g;
		logic r;
		logic b;
		logic i;
	} rgbi_t;

	// 16k ram bank number
	typedef logic [2:0] ram_page_t;

	typedef logic rom_bank_t;

endpackage

`default_nettype wire

// File: raster_if.sv
`timescale 1ns/100ps
`default_nettype none

interface raster_if;
	zxula_pkg::hcount_t hc;
	zxula_pkg::vcount_t vc;
	// high on the second clk14 of a pixel
	logic ck7;
	logic [3:0] pix_phase;
	logic line_end;
	logic blank;
	logic hsync;
	logic vsync;
	logic screen_load;

	modport timer (output hc, vc, ck7, pix_phase, line_end, blank, hsync, vsync, screen_load);
	modport fetch (input hc, vc, ck7, pix_phase, line_end, blank, hsync, vsync, screen_load);
	modport decode (input hc, vc, ck7, pix_phase, line_end, blank, hsync, vsync, screen_load);
endinterface

`default_nettype wire

// File: raster_timer.sv
`timescale 1ns/100ps
`default_nettype none
`include "zxula_macros.svh"

module raster_timer (
	input  logic                   clk14,
	input  logic                   rst_n,
	input  zxula_pkg::frame_fmt_e  fmt,
	raster_if.timer                rif,
	output logic                   n_int,
	output logic                   clkcpu
);

	// double rate column counter with the half pixel phase in bit 0
	logic [9:0] hc0;
	zxula_pkg::vcount_t vc;
	zxula_pkg::hcount_t hc;

	zxula_pkg::hcount_t h_total, hsync_from, hsync_to, hblank_from, hblank_to;
	zxula_pkg::hcount_t int_from, int_to;
	zxula_pkg::vcount_t v_total, vsync_from, vsync_to, int_v;
	logic frame_end;
	logic in_vsync;

	always_comb begin
		if (fmt == zxula_pkg::FMT_S128) begin
			h_total     = zxula_pkg::hcount_t'(`ZX_S128_H_TOTAL);
			hblank_from = zxula_pkg::hcount_t'(`ZX_H_AREA + `ZX_S128_H_RBORDER);
			hsync_from  = zxula_pkg::hcount_t'(`ZX_H_AREA + `ZX_S128_H_RBORDER + `ZX_S128_H_BLANK1);
			hsync_to    = hsync_from + zxula_pkg::hcount_t'(`ZX_S128_H_SYNC);
			hblank_to   = hsync_to + zxula_pkg::hcount_t'(`ZX_S128_H_BLANK2);
			v_total     = zxula_pkg::vcount_t'(`ZX_S128_V_TOTAL);
			vsync_from  = zxula_pkg::vcount_t'(`ZX_V_AREA + `ZX_S128_V_BBORDER);
			vsync_to    = vsync_from + zxula_pkg::vcount_t'(`ZX_S128_V_SYNC);
			int_v       = zxula_pkg::vcount_t'(`ZX_S128_INT_V);
			int_from    = zxula_pkg::hcount_t'(`ZX_S128_INT_H_FROM);
			int_to      = zxula_pkg::hcount_t'(`ZX_S128_INT_H_TO);
		end else begin
			h_total     = zxula_pkg::hcount_t'(`ZX_PENT_H_TOTAL);
			hblank_from = zxula_pkg::hcount_t'(`ZX_H_AREA + `ZX_PENT_H_RBORDER);
			hsync_from  = zxula_pkg::hcount_t'(`ZX_H_AREA + `ZX_PENT_H_RBORDER + `ZX_PENT_H_BLANK1);
			hsync_to    = hsync_from + zxula_pkg::hcount_t'(`ZX_PENT_H_SYNC);
			hblank_to   = hsync_to + zxula_pkg::hcount_t'(`ZX_PENT_H_BLANK2);
			v_total     = zxula_pkg::vcount_t'(`ZX_PENT_V_TOTAL);
			vsync_from  = zxula_pkg::vcount_t'(`ZX_V_AREA + `ZX_PENT_V_BBORDER);
			vsync_to    = vsync_from + zxula_pkg::vcount_t'(`ZX_PENT_V_SYNC);
			int_v       = zxula_pkg::vcount_t'(`ZX_PENT_INT_V);
			int_from    = zxula_pkg::hcount_t'(`ZX_PENT_INT_H_FROM);
			int_to      = zxula_pkg::hcount_t'(`ZX_PENT_INT_H_TO);
		end
	end

	assign hc = hc0[9:1];
	// last clk14 of the line is 2*h_total-1
	assign rif.line_end = (hc0 == {h_total - 9'd1, 1'b1});
	assign frame_end = (vc == v_total - 9'd1);

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			hc0 <= '0;
			vc <= '0;
		end else if (rif.line_end) begin
			hc0 <= '0;
			vc <= frame_end ? 9'd0 : vc + 9'd1;
		end else begin
			hc0 <= hc0 + 10'd1;
		end
	end

	assign in_vsync = (vc >= vsync_from) && (vc < vsync_to);

	assign rif.hc = hc;
	assign rif.vc = vc;
	assign rif.ck7 = hc0[0];
	assign rif.pix_phase = hc0[3:0];
	assign rif.hsync = (hc >= hsync_from) && (hc < hsync_to);
	assign rif.vsync = in_vsync;
	assign rif.blank = in_vsync || ((hc >= hblank_from) && (hc < hblank_to));
	// fetch runs one clk14 ahead, so the line end primes the first column
	assign rif.screen_load = (vc < 9'(`ZX_V_AREA)) && ((hc < 9'(`ZX_H_AREA)) || rif.line_end);

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n)
			n_int <= 1'b1;
		else
			n_int <= !((vc == int_v) && (hc >= int_from) && (hc < int_to));
	end

	// cpu clock toggles every pixel on the falling edge
	always_ff @(negedge clk14 or negedge rst_n) begin
		if (!rst_n)
			clkcpu <= 1'b0;
		else
			clkcpu <= hc[0];
	end

	// vsync may only move at a line boundary
	a_vsync_on_line: assert property (@(posedge clk14) disable iff (!rst_n)
		(rif.vsync != $past(rif.vsync)) |-> $past(rif.line_end));

	a_hc_range: assert property (@(posedge clk14) disable iff (!rst_n)
		hc < h_total);

endmodule

`default_nettype wire

// File: screen_fetch.sv
`timescale 1ns/100ps
`default_nettype none
`include "zxula_macros.svh"

module screen_fetch (
	input  logic              clk14,
	input  logic              rst_n,
	raster_if.fetch           rif,
	input  logic              cpu_busy,
	input  logic [7:0]        vram_data,
	input  logic [2:0]        border,
	output logic              screen_read,
	output logic [13:0]       screen_addr,
	output zxula_pkg::rgbi_t  rgbi,
	output logic              hsync,
	output logic              vsync,
	output logic              csync
);

	logic [7:0] bitmap, attr;
	logic [7:0] bitmap_next, attr_next;
	logic [13:0] bitmap_addr, attr_addr;
	logic attr_read, bitmap_read;
	logic screen_show, screen_update;
	logic [2:0] colour;

	// bitmap rows are interleaved in thirds, attributes are linear from 1800h
	assign bitmap_addr = {1'b0, rif.vc[7:6], rif.vc[2:0], rif.vc[5:3], rif.hc[7:3]};
	assign attr_addr = {4'b0110, rif.vc[7:3], rif.hc[7:3]};
	assign screen_addr = rif.ck7 ? bitmap_addr : attr_addr;

	assign attr_read = screen_read && !rif.ck7;
	assign bitmap_read = screen_read && rif.ck7;

	// window in which shifted screen pixels reach the output
	assign screen_show = (rif.vc < 9'(`ZX_V_AREA)) &&
		(rif.hc >= 9'(`ZX_SCREEN_DELAY - 1)) &&
		(rif.hc < 9'(`ZX_H_AREA + `ZX_SCREEN_DELAY - 1));
	// last half pixel of each 8 pixel group
	assign screen_update = (rif.vc < 9'(`ZX_V_AREA)) && (rif.hc != 9'd0) &&
		(rif.hc <= 9'(`ZX_H_AREA)) && (rif.pix_phase == 4'he);

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n)
			screen_read <= 1'b0;
		else
			screen_read <= rif.screen_load && !cpu_busy;
	end

	always_ff @(posedge clk14) begin
		if (attr_read)
			attr_next <= vram_data;
		if (bitmap_read)
			bitmap_next <= vram_data;
	end

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			attr <= '0;
			bitmap <= '0;
		end else begin
			// border shows as paper with bright off
			if (!screen_show)
				attr <= {2'b00, border, 3'b000};
			else if (screen_update)
				attr <= attr_next;

			if (screen_update)
				bitmap <= bitmap_next;
			else if (rif.ck7)
				bitmap <= {bitmap[6:0], 1'b0};
		end
	end

	// ink for a set bit, paper otherwise
	assign colour = bitmap[7] ? attr[2:0] : attr[5:3];

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			rgbi <= '0;
			hsync <= 1'b0;
			vsync <= 1'b0;
			csync <= 1'b1;
		end else if (rif.ck7) begin
			if (rif.blank) begin
				rgbi <= '0;
			end else begin
				rgbi.g <= colour[2];
				rgbi.r <= colour[1];
				rgbi.b <= colour[0];
				rgbi.i <= attr[6] & (|colour);
			end
			hsync <= rif.hsync;
			vsync <= rif.vsync;
			csync <= ~(rif.hsync ^ rif.vsync);
		end
	end

	// screen reads only come from the active rows
	a_read_in_window: assert property (@(posedge clk14) disable iff (!rst_n)
		screen_read |-> ($past(rif.vc) < 9'(`ZX_V_AREA)));

endmodule

`default_nettype wire

// File: io_ports.sv
`timescale 1ns/100ps
`default_nettype none

module io_ports (
	input  logic                  clk14,
	input  logic                  rst_n,
	input  logic                  a15,
	input  logic                  a14,
	input  logic                  a13,
	input  logic                  a1,
	input  logic                  a0,
	input  logic                  n_iorq,
	input  logic                  n_rd,
	input  logic                  n_wr,
	input  logic [7:0]            data_in,
	input  logic [4:0]            kd,
	input  logic                  tape_in,
	output logic [7:0]            data_out,
	output logic                  data_oe,
	output logic [2:0]            border,
	output logic                  beeper,
	output logic                  tape_out,
	output logic                  snd,
	output zxula_pkg::ram_page_t  ram_page,
	output logic                  vbank,
	output zxula_pkg::rom_bank_t  rom_bank
);

	logic port_fe_cs, port_7ffd_cs;
	logic [4:0] port_fe;
	logic [5:0] port_7ffd;
	logic lock_7ffd;
	logic [8:0] snd_acc;

	assign port_fe_cs = !n_iorq && !a0;
	assign port_7ffd_cs = !n_iorq && !a1 && !a15 && (a14 || a13);
	assign lock_7ffd = port_7ffd[5];

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			port_fe <= '0;
			port_7ffd <= '0;
			data_oe <= 1'b0;
		end else begin
			if (port_fe_cs && !n_wr)
				port_fe <= data_in[4:0];
			// paging freezes once the lock bit is set
			if (port_7ffd_cs && !n_wr && !lock_7ffd)
				port_7ffd <= data_in[5:0];
			data_oe <= port_fe_cs && !n_rd;
		end
	end

	assign data_out = data_oe ? {1'b1, tape_in, 1'b1, kd} : 8'h00;

	assign border = port_fe[2:0];
	assign beeper = port_fe[4];
	assign tape_out = port_fe[3] ^ tape_in;

	assign ram_page = port_7ffd[2:0];
	assign vbank = port_7ffd[3];
	assign rom_bank = port_7ffd[4];

	// first order sigma-delta, carry out is the 1-bit sound
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			snd_acc <= '0;
			snd <= 1'b0;
		end else begin
			{snd, snd_acc} <= {1'b0, snd_acc} + {3'b000, beeper, tape_out, tape_in, 4'b0000};
		end
	end

endmodule

`default_nettype wire

// File: memory_map.sv
`timescale 1ns/100ps
`default_nettype none

module memory_map (
	input  logic                  clk14,
	input  logic                  rst_n,
	input  logic                  a15,
	input  logic                  a14,
	input  logic                  a13,
	input  logic [12:0]           cpu_addr_lo,
	input  logic                  n_mreq,
	input  logic                  n_rfsh,
	input  logic                  n_rd,
	input  logic                  n_wr,
	input  zxula_pkg::ram_page_t  ram_page,
	input  logic                  vbank,
	input  zxula_pkg::rom_bank_t  rom_bank,
	input  logic                  screen_read,
	input  logic [13:0]           screen_addr,
	output logic                  n_romcs,
	output logic                  n_vrd,
	output logic                  n_vwr,
	output logic [16:0]           vram_addr,
	output logic                  rom_a14
);

	logic n_romcs0, n_ramcs, n_vwr0;
	// bank and a13, the 8k half of the page
	logic [3:0] ram_a;
	zxula_pkg::ram_page_t page;
	logic mem_cycle;

	assign mem_cycle = !n_mreq && n_rfsh;

	// 4000h is bank 5, 8000h is bank 2, c000h follows #7ffd
	assign page = (a15 && a14) ? ram_page : {a14, a15, a14};

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			n_romcs0 <= 1'b1;
			n_ramcs <= 1'b1;
			n_vwr0 <= 1'b1;
			ram_a <= '0;
		end else begin
			n_romcs0 <= !(mem_cycle && !a15 && !a14);
			n_ramcs <= !(mem_cycle && (a15 || a14));
			n_vwr0 <= !(mem_cycle && (a15 || a14)) || n_wr || screen_read;
			ram_a <= {page, a13};
		end
	end

	assign n_romcs = n_romcs0 | n_mreq;
	// screen fetch owns the vram read strobe while active
	assign n_vrd = (n_ramcs | n_rd) & ~screen_read;
	assign n_vwr = n_vwr0 | n_wr;

	// video bank is 5, or 7 with vbank set
	assign vram_addr = screen_read ? {1'b1, vbank, 1'b1, screen_addr} : {ram_a, cpu_addr_lo};
	assign rom_a14 = rom_bank;

	a_no_write_on_fetch: assert property (@(posedge clk14) disable iff (!rst_n)
		screen_read |-> n_vwr);

endmodule

`default_nettype wire

// File: zx_ula.sv
`timescale 1ns/100ps
`default_nettype none

module zx_ula (
	input  logic        clk14,
	input  logic        rst_n,
	input  logic        timings_128,
	input  logic [15:0] a,
	input  logic [7:0]  data_in,
	output logic [7:0]  data_out,
	output logic        data_oe,
	input  logic        n_mreq,
	input  logic        n_iorq,
	input  logic        n_rd,
	input  logic        n_wr,
	input  logic        n_m1,
	input  logic        n_rfsh,
	input  logic [4:0]  kd,
	input  logic        tape_in,
	output logic [16:0] vram_addr,
	input  logic [7:0]  vram_data,
	output logic        n_vrd,
	output logic        n_vwr,
	output logic        n_romcs,
	output logic        rom_a14,
	output logic        n_int,
	output logic        clkcpu,
	output logic        r,
	output logic        g,
	output logic        b,
	output logic        i,
	output logic        hsync,
	output logic        vsync,
	output logic        csync,
	output logic        beeper,
	output logic        tape_out,
	output logic        snd
);

	logic [2:0] border;
	zxula_pkg::ram_page_t ram_page;
	logic vbank;
	zxula_pkg::rom_bank_t rom_bank;
	logic screen_read;
	logic [13:0] screen_addr;
	zxula_pkg::rgbi_t rgbi;
	logic cpu_busy;

	raster_if rif ();

	// any cpu bus cycle except refresh holds off the screen fetch
	assign cpu_busy = (!n_mreq && n_rfsh) || !n_iorq || !n_m1;

	assign r = rgbi.r;
	assign g = rgbi.g;
	assign b = rgbi.b;
	assign i = rgbi.i;

	raster_timer u_timer (
		.clk14  (clk14),
		.rst_n  (rst_n),
		.fmt    (zxula_pkg::frame_fmt_e'(timings_128)),
		.rif    (rif.timer),
		.n_int  (n_int),
		.clkcpu (clkcpu)
	);

	screen_fetch u_fetch (
		.clk14       (clk14),
		.rst_n       (rst_n),
		.rif         (rif.fetch),
		.cpu_busy    (cpu_busy),
		.vram_data   (vram_data),
		.border      (border),
		.screen_read (screen_read),
		.screen_addr (screen_addr),
		.rgbi        (rgbi),
		.hsync       (hsync),
		.vsync       (vsync),
		.csync       (csync)
	);

	io_ports u_io (
		.clk14    (clk14),
		.rst_n    (rst_n),
		.a15      (a[15]),
		.a14      (a[14]),
		.a13      (a[13]),
		.a1       (a[1]),
		.a0       (a[0]),
		.n_iorq   (n_iorq),
		.n_rd     (n_rd),
		.n_wr     (n_wr),
		.data_in  (data_in),
		.kd       (kd),
		.tape_in  (tape_in),
		.data_out (data_out),
		.data_oe  (data_oe),
		.border   (border),
		.beeper   (beeper),
		.tape_out (tape_out),
		.snd      (snd),
		.ram_page (ram_page),
		.vbank    (vbank),
		.rom_bank (rom_bank)
	);

	memory_map u_mem (
		.clk14       (clk14),
		.rst_n       (rst_n),
		.a15         (a[15]),
		.a14         (a[14]),
		.a13         (a[13]),
		.cpu_addr_lo (a[12:0]),
		.n_mreq      (n_mreq),
		.n_rfsh      (n_rfsh),
		.n_rd        (n_rd),
		.n_wr        (n_wr),
		.ram_page    (ram_page),
		.vbank       (vbank),
		.rom_bank    (rom_bank),
		.screen_read (screen_read),
		.screen_addr (screen_addr),
		.n_romcs     (n_romcs),
		.n_vrd       (n_vrd),
		.n_vwr       (n_vwr),
		.vram_addr   (vram_addr),
		.rom_a14     (rom_a14)
	);

endmodule

`default_nettype wire

// File: tb_zx_ula.sv
`timescale 1ns/100ps
`default_nettype none
`include "zxula_macros.svh"

module tb_zx_ula;

	localparam integer cycle_limit = (4 * (2 * `ZX_PENT_H_TOTAL * `ZX_PENT_V_TOTAL +
		2 * `ZX_S128_H_TOTAL * `ZX_S128_V_TOTAL) * 11) / 10;

	logic clk14, rst_n, timings_128;
	logic [15:0] a;
	logic [7:0] data_in, data_out;
	logic data_oe;
	logic n_mreq, n_iorq, n_rd, n_wr, n_m1, n_rfsh;
	logic [4:0] kd;
	logic tape_in;
	logic [16:0] vram_addr;
	logic [7:0] vram_data;
	logic n_vrd, n_vwr, n_romcs, rom_a14, n_int, clkcpu;
	logic r, g, b, i, hsync, vsync, csync;
	logic beeper, tape_out, snd;

	logic [7:0] vram [0:131071];
	logic [31:0] lfsr_state;
	// reference double rate column and line counters
	logic [9:0] tb_h2;
	logic [8:0] tb_vc;
	integer checks, errors, cycles;
	integer pix_line;
	logic pix_en;

	zx_ula u_dut (
		.clk14(clk14), .rst_n(rst_n), .timings_128(timings_128), .a(a),
		.data_in(data_in), .data_out(data_out), .data_oe(data_oe),
		.n_mreq(n_mreq), .n_iorq(n_iorq), .n_rd(n_rd), .n_wr(n_wr),
		.n_m1(n_m1), .n_rfsh(n_rfsh), .kd(kd), .tape_in(tape_in),
		.vram_addr(vram_addr), .vram_data(vram_data), .n_vrd(n_vrd), .n_vwr(n_vwr),
		.n_romcs(n_romcs), .rom_a14(rom_a14), .n_int(n_int), .clkcpu(clkcpu),
		.r(r), .g(g), .b(b), .i(i), .hsync(hsync), .vsync(vsync), .csync(csync),
		.beeper(beeper), .tape_out(tape_out), .snd(snd)
	);

	assign vram_data = vram[vram_addr];

	initial begin
		clk14 = 1'b0;
		forever #20 clk14 = ~clk14;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] take_bits(input integer n);
		logic [31:0] v;
		integer k;
		v = '0;
		for (k = 0; k < n; k++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		take_bits = v;
	endfunction

	function automatic integer line_cycles(input logic s128);
		line_cycles = 2 * (s128 ? `ZX_S128_H_TOTAL : `ZX_PENT_H_TOTAL);
	endfunction

	function automatic integer frame_lines(input logic s128);
		frame_lines = s128 ? `ZX_S128_V_TOTAL : `ZX_PENT_V_TOTAL;
	endfunction

	function automatic integer frame_cycles(input logic s128);
		frame_cycles = line_cycles(s128) * frame_lines(s128);
	endfunction

	function automatic integer hsync_cycles(input logic s128);
		hsync_cycles = 2 * (s128 ? `ZX_S128_H_SYNC : `ZX_PENT_H_SYNC);
	endfunction

	function automatic integer vsync_cycles(input logic s128);
		vsync_cycles = (s128 ? `ZX_S128_V_SYNC : `ZX_PENT_V_SYNC) * line_cycles(s128);
	endfunction

	function automatic integer int_cycles(input logic s128);
		if (s128)
			int_cycles = 2 * (`ZX_S128_INT_H_TO - `ZX_S128_INT_H_FROM);
		else
			int_cycles = 2 * (`ZX_PENT_INT_H_TO - `ZX_PENT_INT_H_FROM);
	endfunction

	function automatic logic [16:0] screen_base(input logic vbank);
		screen_base = vbank ? 17'h1c000 : 17'h14000;
	endfunction

	function automatic logic [13:0] bitmap_offset(input logic [7:0] y, input logic [7:0] x);
		bitmap_offset = 14'(y[7:6]) * 14'd2048 + 14'(y[2:0]) * 14'd256 +
			14'(y[5:3]) * 14'd32 + 14'(x >> 3);
	endfunction

	function automatic logic [13:0] attr_offset(input logic [7:0] y, input logic [7:0] x);
		attr_offset = 14'h1800 + 14'(y >> 3) * 14'd32 + 14'(x >> 3);
	endfunction

	// {g, r, b, i} for one pixel of a bitmap byte
	function automatic logic [3:0] pixel_colour(input logic [7:0] bits, input logic [7:0] attr,
		input logic [2:0] col);
		logic [2:0] c;
		c = bits[3'd7 - col] ? attr[2:0] : attr[5:3];
		pixel_colour = {c[2], c[1], c[0], attr[6] & (|c)};
	endfunction

	function automatic logic [2:0] page_for_addr(input logic [15:0] addr, input logic [2:0] sel);
		case (addr[15:14])
			2'b01: page_for_addr = 3'd5;
			2'b10: page_for_addr = 3'd2;
			default: page_for_addr = sel;
		endcase
	endfunction

	function automatic integer snd_ones(input integer n, input logic beep, input logic tout,
		input logic tin);
		snd_ones = n * (beep * 64 + tout * 32 + tin * 16) / 512;
	endfunction

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks = checks + 1;
		assert (got === exp) else begin
			errors = errors + 1;
			$display("ERR %0t: %s, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	always @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			tb_h2 <= '0;
			tb_vc <= '0;
		end else if (tb_h2 == 10'(line_cycles(timings_128) - 1)) begin
			tb_h2 <= '0;
			tb_vc <= (tb_vc == 9'(frame_lines(timings_128) - 1)) ? 9'd0 : tb_vc + 9'd1;
		end else begin
			tb_h2 <= tb_h2 + 10'd1;
		end
	end

	always @(posedge clk14) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("run stopped, no result after %0d clock cycles", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	// column x of the selected line shows up at hc = x + 8
	always @(negedge clk14) begin : pixel_compare
		integer x;
		logic [3:0] want;
		if (pix_en && tb_vc == pix_line && !tb_h2[0] && tb_h2 >= 16 && tb_h2 < 528) begin
			x = tb_h2 / 2 - 8;
			want = pixel_colour(vram[screen_base(1'b0) + bitmap_offset(8'(pix_line), 8'(x))],
				vram[screen_base(1'b0) + attr_offset(8'(pix_line), 8'(x))], 3'(x));
			checks = checks + 1;
			assert ({g, r, b, i} === want) else begin
				errors = errors + 1;
				$display("ERR %0t: pixel x=%0d y=%0d, got %h expected %h", $time, x, pix_line,
					{g, r, b, i}, want);
			end
		end
	end

	task automatic apply_reset(input logic s128);
		@(negedge clk14);
		rst_n = 1'b0;
		timings_128 = s128;
		repeat (4) @(negedge clk14);
		rst_n = 1'b1;
	endtask

	task automatic wait_pos(input integer line, input integer h2);
		@(negedge clk14);
		while (!(tb_vc == line && tb_h2 == h2))
			@(negedge clk14);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] val);
		@(negedge clk14);
		a = addr;
		data_in = val;
		n_iorq = 1'b0;
		n_wr = 1'b0;
		@(negedge clk14);
		n_iorq = 1'b1;
		n_wr = 1'b1;
		a = '0;
	endtask

	// one frame from vsync rise to vsync rise
	task automatic measure_frame(input logic s128);
		integer cyc, hs_run, vs_run, int_run, int_falls, cs_bad;
		logic prev_vs, prev_hs, prev_int, done;
		prev_vs = 1'b1;
		@(negedge clk14);
		while (!(vsync && !prev_vs)) begin
			prev_vs = vsync;
			@(negedge clk14);
		end
		cyc = 0;
		cs_bad = 0;
		int_falls = 0;
		hs_run = hsync ? 1 : 0;
		vs_run = 1;
		int_run = n_int ? 0 : 1;
		prev_vs = vsync;
		prev_hs = hsync;
		prev_int = n_int;
		done = 1'b0;
		while (!done) begin
			@(negedge clk14);
			cyc = cyc + 1;
			if (vsync && !prev_vs) begin
				done = 1'b1;
			end else begin
				if (csync !== ~(hsync ^ vsync))
					cs_bad = cs_bad + 1;
				if (hsync)
					hs_run = hs_run + 1;
				else if (prev_hs) begin
					check_eq(hs_run, hsync_cycles(s128), "hsync width");
					hs_run = 0;
				end
				if (vsync)
					vs_run = vs_run + 1;
				if (!n_int)
					int_run = int_run + 1;
				if (!n_int && prev_int)
					int_falls = int_falls + 1;
			end
			prev_vs = vsync;
			prev_hs = hsync;
			prev_int = n_int;
		end
		check_eq(cyc, frame_cycles(s128), "vsync period");
		check_eq(vs_run, vsync_cycles(s128), "vsync width");
		check_eq(int_falls, 1, "n_int falls per frame");
		check_eq(int_run, int_cycles(s128), "n_int low time");
		check_eq(cs_bad, 0, "csync mismatches");
	endtask

	// clkcpu is hc bit 0 taken on the previous falling edge
	task automatic clkcpu_check();
		integer bad;
		bad = 0;
		repeat (64) begin
			@(posedge clk14);
			if (clkcpu !== tb_h2[1])
				bad = bad + 1;
		end
		check_eq(bad, 0, "clkcpu mismatches");
	endtask

	task automatic check_line(input integer y);
		pix_line = y;
		wait_pos(y, 0);
		pix_en = 1'b1;
		wait_pos(y, 2 * (`ZX_H_AREA + `ZX_SCREEN_DELAY));
		pix_en = 1'b0;
	endtask

	task automatic sound_check(input logic [7:0] v);
		integer ones;
		logic tout;
		io_write(16'h00fe, v);
		repeat (4) @(negedge clk14);
		tout = v[3] ^ tape_in;
		check_eq(beeper, v[4], "beeper");
		check_eq(tape_out, tout, "tape_out");
		ones = 0;
		repeat (1024) begin
			@(negedge clk14);
			if (snd)
				ones = ones + 1;
		end
		check_eq(ones, snd_ones(1024, v[4], tout, tape_in), "snd ones in 1024 cycles");
	endtask

	task automatic fe_read_check();
		logic [4:0] keys;
		keys = 5'(take_bits(5));
		@(negedge clk14);
		a = 16'h00fe;
		kd = keys;
		tape_in = 1'b1;
		n_iorq = 1'b0;
		n_rd = 1'b0;
		@(negedge clk14);
		check_eq(data_oe, 1'b1, "data_oe on #fe read");
		check_eq(data_out, {1'b1, tape_in, 1'b1, keys}, "#fe read data");
		n_iorq = 1'b1;
		n_rd = 1'b1;
		a = '0;
		tape_in = 1'b0;
		@(negedge clk14);
		check_eq(data_oe, 1'b0, "data_oe after read");
	endtask

	task automatic mem_read_check(input logic [15:0] addr, input logic [7:0] p);
		logic rom_sel;
		rom_sel = (addr < 16'h4000);
		@(negedge clk14);
		a = addr;
		n_mreq = 1'b0;
		n_rd = 1'b0;
		repeat (2) @(negedge clk14);
		check_eq(n_romcs, !rom_sel, $sformatf("n_romcs at %h", addr));
		check_eq(n_vrd, rom_sel, $sformatf("n_vrd at %h", addr));
		check_eq(n_vwr, 1'b1, "n_vwr on a read");
		check_eq(rom_a14, p[4], "rom_a14");
		if (!rom_sel)
			check_eq(vram_addr, {page_for_addr(addr, p[2:0]), addr[13:0]},
				$sformatf("vram_addr for %h", addr));
		n_mreq = 1'b1;
		n_rd = 1'b1;
		a = '0;
	endtask

	task automatic paging_check();
		logic [7:0] p_open, p_lock;
		integer k;
		p_open = 8'(take_bits(5));
		io_write(16'h7ffd, p_open);
		mem_read_check(16'hc000 | 16'(take_bits(14)), p_open);
		// once the lock is set a further write is ignored
		p_lock = 8'h20 | 8'(take_bits(5));
		io_write(16'h7ffd, p_lock);
		io_write(16'h7ffd, p_lock ^ 8'h17);
		mem_read_check(16'hc000 | 16'(take_bits(14)), p_lock);
		for (k = 0; k < 8; k++)
			mem_read_check({2'(k), 14'(take_bits(14))}, p_lock);
	endtask

	task automatic run_format(input logic s128);
		logic [7:0] v;
		apply_reset(s128);
		measure_frame(s128);
		clkcpu_check();
		check_line(s128 ? 150 : 77);
		v = 8'h10 | 8'(take_bits(3));
		sound_check(v);
		// sample the bottom border well clear of blanking
		wait_pos(200, 200);
		check_eq({g, r, b, i}, {v[2:0], 1'b0}, "border colour");
		fe_read_check();
		sound_check(8'h08 | 8'(take_bits(3)));
		sound_check(8'(take_bits(3)));
		paging_check();
	endtask

	initial begin : main
		integer k;
		rst_n = 1'b0;
		timings_128 = 1'b0;
		a = '0;
		data_in = '0;
		n_mreq = 1'b1;
		n_iorq = 1'b1;
		n_rd = 1'b1;
		n_wr = 1'b1;
		n_m1 = 1'b1;
		n_rfsh = 1'b1;
		kd = 5'h1f;
		tape_in = 1'b0;
		pix_en = 1'b0;
		pix_line = 0;
		checks = 0;
		errors = 0;
		cycles = 0;
		lfsr_state = 32'h615f;
		for (k = 0; k < 131072; k++)
			vram[k] = 8'(take_bits(8));

		run_format(1'b0);
		run_format(1'b1);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: zx_ula.f
+incdir+.
zxula_pkg.sv
raster_if.sv
raster_timer.sv
screen_fetch.sv
io_ports.sv
memory_map.sv
zx_ula.sv
tb_zx_ula.sv
